/* flist.f */
+incdir+.
rx_dsp_pkg.sv
rx_ctrl_pkg.sv
rx_cfg_regs.sv
rx_ffe.sv
rx_mm_pd.sv
rx_top.sv
rx_checker.sv
rx_tb.sv

/* Makefile */
BUILD = obj_dir
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module rx_tb \
		--Mdir $(BUILD) -o Vrx_tb
	./$(BUILD)/Vrx_tb +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	elif ! grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* rx_tb.sv */
`timescale 1ns/100ps

`include "rx_params.svh"

module rx_tb;
    import rx_dsp_pkg::*;
    import rx_ctrl_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int N_IDENT     = 200;
    localparam int N_ROUNDS    = 6;
    localparam int N_ROUND     = 120;
    localparam int N_GAP       = 300;
    localparam int N_RAMP      = 2600;
    localparam int N_FROZEN    = 200;
    localparam int N_RESUME    = 400;
    localparam int CFG_CYCLES  = 9;
    localparam int STIM_CYCLES = 4 + N_IDENT + N_ROUNDS * (CFG_CYCLES + N_ROUND) + N_GAP
                               + CFG_CYCLES + N_RAMP + N_FROZEN + N_RESUME + 40;
    localparam int WATCHDOG_NS = (STIM_CYCLES + 200) * CLK_PERIOD;
    localparam int OFFSET      = 20;
    localparam int SWING       = 60;
    localparam int OUT_HI      = (1 << (`RX_OUT_W - 1)) - 1;
    localparam int OUT_LO      = -(1 << (`RX_OUT_W - 1));
    localparam int ACC_MAX     = (1 << `RX_ACC_W) - 1;
    localparam int DEL_SHIFT   = `RX_ACC_W - `RX_DEL_W;

    logic                 clk;
    logic                 rst_n;
    adc_code_t            code;
    logic                 cfg_wr;
    cfg_cmd_t             cfg_cmd;
    eq_sample_t           eq;
    logic [`RX_DEL_W-1:0] del_code;

    // Reference model state
    int          taps_m [`RX_FFE_DEPTH];
    int          hist_m [`RX_FFE_DEPTH];
    int          shift_m;
    bit          freeze_m;
    int          acc_m;
    int          prev_val_m;
    bit          prev_dec_m;
    int          exp_q [$];
    bit          del_pending;
    int          checks;
    int          errors;
    logic [31:0] lcg_state;

    rx_top u_dut (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .code_i     (code),
        .cfg_wr_i   (cfg_wr),
        .cfg_i      (cfg_cmd),
        .eq_o       (eq),
        .del_code_o (del_code)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int rand_range(input int lo, input int hi);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lo + int'({16'd0, lcg_state[31:16]}) % (hi - lo + 1);
    endfunction

    // FIR over the last valid codes, floor shift, then saturation
    function automatic int ffe_ref();
        int sum;
        int val;
        sum = 0;
        for (int k = 0; k < `RX_FFE_DEPTH; k++) begin
            sum = sum + taps_m[k] * hist_m[k];
        end
        val = sum >>> shift_m;
        if (val > OUT_HI) begin
            val = OUT_HI;
        end else if (val < OUT_LO) begin
            val = OUT_LO;
        end
        return val;
    endfunction

    // Sign of the Mueller-Muller term
    function automatic int mm_error(input int prev_val, input bit prev_dec,
                                    input int cur_val, input bit cur_dec);
        int term;
        term = (prev_dec ? cur_val : -cur_val) - (cur_dec ? prev_val : -prev_val);
        if (term > 0) begin
            return 1;
        end else if (term < 0) begin
            return -1;
        end
        return 0;
    endfunction

    // Three codes around an offset, each step pushes the loop the same way
    function automatic int ramp_code(input int i, input bit up);
        int phase;
        phase = i % 3;
        if (up) begin
            return (phase == 0) ? OFFSET : (phase == 1) ? OFFSET + SWING : OFFSET - SWING;
        end
        return (phase == 0) ? OFFSET - SWING : (phase == 1) ? OFFSET + SWING : OFFSET;
    endfunction

    task automatic check_value(input string what, input logic signed [31:0] got, input int exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic send_code(input bit valid, input int value);
        code.valid = valid;
        code.code  = value[`RX_CODE_W-1:0];
        if (valid) begin
            for (int k = `RX_FFE_DEPTH - 1; k > 0; k--) begin
                hist_m[k] = hist_m[k-1];
            end
            hist_m[0] = value;
            exp_q.push_back(ffe_ref());
        end
        @(negedge clk);
    endtask

    task automatic idle(input int n);
        repeat (n) send_code(1'b0, 0);
    endtask

    task automatic write_cfg(input cfg_op_e op, input int addr, input int data);
        cfg_wr       = 1'b1;
        cfg_cmd.op   = op;
        cfg_cmd.addr = addr[CFG_ADDR_W-1:0];
        cfg_cmd.data = data[CFG_DATA_W-1:0];
        case (op)
            CFG_SET_TAP:    taps_m[addr] = int'($signed(data[`RX_WEIGHT_W-1:0]));
            CFG_SET_SHIFT:  shift_m = int'(data[`RX_SHIFT_W-1:0]);
            CFG_SET_FREEZE: freeze_m = data[0];
            default:        ;
        endcase
        @(negedge clk);
        cfg_wr = 1'b0;
    endtask

    // Pipeline drains first so no sample sees a half-written setting
    task automatic program_ffe(input int t0, t1, t2, t3, input int shift);
        idle(4);
        write_cfg(CFG_SET_TAP, 0, t0);
        write_cfg(CFG_SET_TAP, 1, t1);
        write_cfg(CFG_SET_TAP, 2, t2);
        write_cfg(CFG_SET_TAP, 3, t3);
        write_cfg(CFG_SET_SHIFT, 0, shift);
    endtask

    // Outputs only change on the rising edge
    always @(negedge clk) begin : compare_outputs
        int exp_val;
        int pd_err;
        if (rst_n) begin
            // Delay code follows each valid output one cycle later
            if (del_pending) begin
                check_value("del_code_o", 32'(del_code), acc_m >> DEL_SHIFT);
                del_pending = 1'b0;
            end
            if (eq.valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Valid output at %0t ns with no input sample in flight", $time);
                end else begin
                    exp_val = exp_q.pop_front();
                    check_value("eq_o value", 32'($signed(eq.value)), exp_val);
                    check_value("eq_o decision", 32'(eq.decision), int'(exp_val > 0));
                    pd_err = mm_error(prev_val_m, prev_dec_m, exp_val, exp_val > 0);
                    if (!freeze_m) begin
                        acc_m = acc_m + pd_err;
                        if (acc_m > ACC_MAX) begin
                            acc_m = ACC_MAX;
                        end else if (acc_m < 0) begin
                            acc_m = 0;
                        end
                    end
                    prev_val_m  = exp_val;
                    prev_dec_m  = exp_val > 0;
                    del_pending = 1'b1;
                end
            end
        end
    end

    initial begin
        rst_n       = 1'b0;
        code        = '0;
        cfg_wr      = 1'b0;
        cfg_cmd     = '0;
        lcg_state   = 32'he1ac_85bf;
        checks      = 0;
        errors      = 0;
        for (int k = 0; k < `RX_FFE_DEPTH; k++) begin
            taps_m[k] = 0;
            hist_m[k] = 0;
        end
        taps_m[0]   = `RX_RST_TAP0;
        shift_m     = `RX_RST_SHIFT;
        freeze_m    = 1'b0;
        acc_m       = `RX_ACC_RST;
        prev_val_m  = 0;
        prev_dec_m  = 1'b0;
        del_pending = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("del_code_o after reset", 32'(del_code), `RX_ACC_RST >> DEL_SHIFT);

        // Reset settings pass codes through unchanged
        repeat (N_IDENT) send_code(1'b1, rand_range(-128, 127));

        // First two rounds hit both saturation limits
        for (int r = 0; r < N_ROUNDS; r++) begin
            if (r == 0) begin
                program_ffe(127, 0, 0, 0, 0);
            end else if (r == 1) begin
                program_ffe(-128, 127, -128, 127, 2);
            end else begin
                program_ffe(rand_range(-128, 127), rand_range(-128, 127),
                            rand_range(-128, 127), rand_range(-128, 127), rand_range(0, 8));
            end
            repeat (N_ROUND) send_code(1'b1, rand_range(-128, 127));
        end

        // Random gaps with the last random taps still loaded
        repeat (N_GAP) send_code(rand_range(0, 1) == 1, rand_range(-128, 127));

        // Biased data walks the loop up to its limit
        program_ffe(`RX_RST_TAP0, 0, 0, 0, `RX_RST_SHIFT);
        for (int i = 0; i < N_RAMP; i++) begin
            send_code(1'b1, ramp_code(i, 1'b1));
        end
        idle(4);
        check_value("del_code_o at upper limit", 32'(del_code), ACC_MAX >> DEL_SHIFT);

        write_cfg(CFG_SET_FREEZE, 0, 1);
        for (int i = 0; i < N_FROZEN; i++) begin
            send_code(1'b1, ramp_code(i, 1'b0));
        end
        idle(4);
        check_value("del_code_o while frozen", 32'(del_code), ACC_MAX >> DEL_SHIFT);
        write_cfg(CFG_SET_FREEZE, 0, 0);
        for (int i = N_FROZEN; i < N_FROZEN + N_RESUME; i++) begin
            send_code(1'b1, ramp_code(i, 1'b0));
        end
        idle(8);
        check_value("del_code_o after resume", 32'(del_code), (ACC_MAX - N_RESUME) >> DEL_SHIFT);
        check_value("samples left in flight", 32'(exp_q.size()), 0);

        errors = errors + u_dut.u_checker.fail_cnt;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, u_dut.u_checker.fail_cnt);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* rx_checker.sv */
`timescale 1ns/100ps

`include "rx_params.svh"

module rx_checker (
    input logic                   clk_i,
    input logic                   rst_n_i,
    input rx_dsp_pkg::adc_code_t  code_i,
    input rx_dsp_pkg::eq_sample_t eq_i,
    input logic                   freeze_i,
    input logic [`RX_DEL_W-1:0]   del_code_i
);

    int lat_fails = 0;
    int rst_fails = 0;
    int frz_fails = 0;
    int fail_cnt;

    assign fail_cnt = lat_fails + rst_fails + frz_fails;

    // Valid is registered two edges after the input edge, so three sampled ticks
    a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        eq_i.valid == $past(code_i.valid, 3))
        else begin
            $error("eq_o valid does not follow code_i valid by two cycles");
            lat_fails = lat_fails + 1;
        end

    a_rst_valid: assert property (@(posedge clk_i) !rst_n_i |=> !eq_i.valid)
        else begin
            $error("eq_o valid is high after reset");
            rst_fails = rst_fails + 1;
        end

    // Frozen integrator keeps the delay code
    a_freeze_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        freeze_i |=> $stable(del_code_i))
        else begin
            $error("del_code_o changed while the loop was frozen");
            frz_fails = frz_fails + 1;
        end

endmodule

bind rx_top rx_checker u_checker (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .code_i     (code_i),
    .eq_i       (eq_o),
    .freeze_i   (pd_freeze),
    .del_code_i (del_code_o)
);

/* rx_top.sv */
`timescale 1ns/100ps

`include "rx_params.svh"

module rx_top (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  rx_dsp_pkg::adc_code_t  code_i,
    input  logic                   cfg_wr_i,
    input  rx_ctrl_pkg::cfg_cmd_t  cfg_i,
    output rx_dsp_pkg::eq_sample_t eq_o,
    output logic [`RX_DEL_W-1:0]   del_code_o
);
    import rx_dsp_pkg::*;
    import rx_ctrl_pkg::*;

    ffe_set_t   ffe_set;
    logic       pd_freeze;
    eq_sample_t eq;

    // Tap, shift and freeze registers
    rx_cfg_regs u_cfg_regs (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cfg_wr_i    (cfg_wr_i),
        .cfg_i       (cfg_i),
        .ffe_set_o   (ffe_set),
        .pd_freeze_o (pd_freeze)
    );

    // Equalizer and slicer, two cycles
    rx_ffe u_ffe (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .code_i    (code_i),
        .ffe_set_i (ffe_set),
        .eq_o      (eq)
    );

    // Timing recovery on the equalized stream
    rx_mm_pd u_mm_pd (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .eq_i       (eq),
        .freeze_i   (pd_freeze),
        .del_code_o (del_code_o)
    );

    assign eq_o = eq;

endmodule

/* rx_mm_pd.sv */
`timescale 1ns/100ps

`include "rx_params.svh"

module rx_mm_pd (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  rx_dsp_pkg::eq_sample_t eq_i,
    input  logic                   freeze_i,
    output logic [`RX_DEL_W-1:0]   del_code_o
);

    // Room for negation and the difference of two output words
    localparam int TERM_W = `RX_OUT_W + 2;

    logic signed [`RX_OUT_W-1:0] prev_val_q;
    logic                        prev_dec_q;
    logic [`RX_ACC_W-1:0]        acc_q;

    logic signed [TERM_W-1:0]    cur_w;
    logic signed [TERM_W-1:0]    prev_w;
    logic signed [TERM_W-1:0]    term_c;
    logic                        err_up;
    logic                        err_dn;

    // Mueller-Muller term, sign(prev) * cur - sign(cur) * prev
    always_comb begin
        cur_w  = eq_i.value;
        prev_w = prev_val_q;
        term_c = (prev_dec_q ? cur_w : -cur_w) - (eq_i.decision ? prev_w : -prev_w);
    end

    // Only the sign of the term steers the loop
    assign err_dn = term_c[TERM_W-1];
    assign err_up = !term_c[TERM_W-1] && (term_c != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            acc_q      <= `RX_ACC_W'(`RX_ACC_RST);
            prev_val_q <= '0;
            prev_dec_q <= 1'b0;
        end else if (eq_i.valid) begin
            // History keeps moving even while the loop is frozen
            prev_val_q <= eq_i.value;
            prev_dec_q <= eq_i.decision;
            if (!freeze_i) begin
                if (err_up && (acc_q != '1)) begin
                    acc_q <= acc_q + 1'b1;
                end else if (err_dn && (acc_q != '0)) begin
                    acc_q <= acc_q - 1'b1;
                end
            end
        end
    end

    // Delay line code is the integrator MSBs
    assign del_code_o = acc_q[`RX_ACC_W-1 -: `RX_DEL_W];

endmodule

/* rx_ffe.sv */
`timescale 1ns/100ps

`include "rx_params.svh"

module rx_ffe (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  rx_dsp_pkg::adc_code_t  code_i,
    input  rx_ctrl_pkg::ffe_set_t  ffe_set_i,
    output rx_dsp_pkg::eq_sample_t eq_o
);
    import rx_dsp_pkg::*;
    import rx_ctrl_pkg::*;

    localparam int PROD_W = `RX_CODE_W + `RX_WEIGHT_W;
    localparam int SUM_W  = PROD_W + $clog2(`RX_FFE_DEPTH);

    // Saturation limits of the output word
    localparam logic signed [SUM_W-1:0] SAT_HI = SUM_W'(2 ** (`RX_OUT_W - 1) - 1);
    localparam logic signed [SUM_W-1:0] SAT_LO = -SUM_W'(2 ** (`RX_OUT_W - 1));

    code_t [`RX_FFE_DEPTH-1:0]   line_q;
    logic                        a_vld_q;
    ffe_set_t                    a_set_q;

    logic signed [PROD_W-1:0]    prod_c [`RX_FFE_DEPTH];
    logic signed [SUM_W-1:0]     sum_c;
    logic signed [SUM_W-1:0]     b_sum_q;
    logic [`RX_SHIFT_W-1:0]      b_shift_q;
    logic                        b_vld_q;

    logic signed [SUM_W-1:0]     shifted_c;
    logic signed [`RX_OUT_W-1:0] sat_c;
    eq_sample_t                  eq_q;

    // Delay line only moves on valid codes
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            line_q  <= '0;
            a_vld_q <= 1'b0;
        end else begin
            a_vld_q <= code_i.valid;
            if (code_i.valid) begin
                line_q <= {line_q[`RX_FFE_DEPTH-2:0], code_i.code};
            end
        end
    end

    // Taps and shift as seen at the input edge
    always_ff @(posedge clk_i) begin
        a_set_q <= ffe_set_i;
    end

    always_comb begin
        sum_c = '0;
        for (int k = 0; k < `RX_FFE_DEPTH; k++) begin
            prod_c[k] = $signed(a_set_q.taps[k]) * $signed(line_q[k]);
            sum_c     = sum_c + prod_c[k];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            b_vld_q <= 1'b0;
        end else begin
            b_vld_q <= a_vld_q;
        end
    end

    always_ff @(posedge clk_i) begin
        b_sum_q   <= sum_c;
        b_shift_q <= a_set_q.shift;
    end

    // Arithmetic shift floors toward minus infinity
    always_comb begin
        shifted_c = b_sum_q >>> b_shift_q;
        if (shifted_c > SAT_HI) begin
            sat_c = SAT_HI[`RX_OUT_W-1:0];
        end else if (shifted_c < SAT_LO) begin
            sat_c = SAT_LO[`RX_OUT_W-1:0];
        end else begin
            sat_c = shifted_c[`RX_OUT_W-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            eq_q.valid <= 1'b0;
        end else begin
            eq_q.valid <= b_vld_q;
        end
    end

    // Slicer, one for strictly positive values
    always_ff @(posedge clk_i) begin
        eq_q.value    <= sat_c;
        eq_q.decision <= (sat_c > 0);
    end

    assign eq_o = eq_q;

endmodule

/* rx_cfg_regs.sv */
`timescale 1ns/100ps

`include "rx_params.svh"

module rx_cfg_regs (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  cfg_wr_i,
    input  rx_ctrl_pkg::cfg_cmd_t cfg_i,
    output rx_ctrl_pkg::ffe_set_t ffe_set_o,
    output logic                  pd_freeze_o
);
    import rx_ctrl_pkg::*;

    ffe_set_t ffe_set_q;
    logic     freeze_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // Identity equalizer and a running loop
            for (int k = 0; k < `RX_FFE_DEPTH; k++) begin
                if (k == 0) begin
                    ffe_set_q.taps[k] <= `RX_WEIGHT_W'(`RX_RST_TAP0);
                end else begin
                    ffe_set_q.taps[k] <= '0;
                end
            end
            ffe_set_q.shift <= `RX_SHIFT_W'(`RX_RST_SHIFT);
            freeze_q        <= 1'b0;
        end else if (cfg_wr_i) begin
            case (cfg_i.op)
                CFG_SET_TAP: begin
                    ffe_set_q.taps[cfg_i.addr] <= cfg_i.data[`RX_WEIGHT_W-1:0];
                end
                CFG_SET_SHIFT: begin
                    ffe_set_q.shift <= cfg_i.data[`RX_SHIFT_W-1:0];
                end
                CFG_SET_FREEZE: begin
                    freeze_q <= cfg_i.data[0];
                end
                default: begin
                    // Unknown opcode, nothing changes
                    freeze_q <= freeze_q;
                end
            endcase
        end
    end

    // Registered settings go straight out
    assign ffe_set_o   = ffe_set_q;
    assign pd_freeze_o = freeze_q;

endmodule

/* rx_ctrl_pkg.sv */
`include "rx_params.svh"

package rx_ctrl_pkg;

    localparam int CFG_ADDR_W = $clog2(`RX_FFE_DEPTH);
    localparam int CFG_DATA_W = 8;

    // Configuration opcodes, code 3 is unused
    typedef enum logic [1:0] {
        CFG_SET_TAP    = 2'd0,
        CFG_SET_SHIFT  = 2'd1,
        CFG_SET_FREEZE = 2'd2
    } cfg_op_e;

    typedef struct packed {
        cfg_op_e                 op;
        logic [CFG_ADDR_W-1:0]   addr;
        logic [CFG_DATA_W-1:0]   data;
    } cfg_cmd_t;

    // Everything the equalizer needs from the register file
    typedef struct packed {
        rx_dsp_pkg::tap_vec_t    taps;
        logic [`RX_SHIFT_W-1:0]  shift;
    } ffe_set_t;

endpackage

/* rx_dsp_pkg.sv */
`include "rx_params.svh"

package rx_dsp_pkg;

    // One signed ADC code
    typedef logic signed [`RX_CODE_W-1:0] code_t;

    // One signed FFE weight
    typedef logic signed [`RX_WEIGHT_W-1:0] tap_t;

    // Tap k applies to the code k samples back
    typedef tap_t [`RX_FFE_DEPTH-1:0] tap_vec_t;

    // Sample from the ADC with its strobe
    typedef struct packed {
        logic  valid;
        code_t code;
    } adc_code_t;

    // Equalized sample and the slicer decision
    typedef struct packed {
        logic                        valid;
        logic signed [`RX_OUT_W-1:0] value;
        logic                        decision;
    } eq_sample_t;

endpackage

/* rx_params.svh */
`ifndef RX_PARAMS_SVH
`define RX_PARAMS_SVH

// ADC code and tap weight sizes
`define RX_CODE_W     8
`define RX_WEIGHT_W   8
`define RX_FFE_DEPTH  4
`define RX_SHIFT_W    4

// Equalizer output, saturated to this many bits
`define RX_OUT_W      10

// Timing loop integrator and delay code taken from its top bits
`define RX_ACC_W      12
`define RX_DEL_W      8

// Tap 0 of 64 with a shift of 6 passes codes through unchanged
`define RX_RST_TAP0   64
`define RX_RST_SHIFT  6

// Mid-scale start, delay code 128
`define RX_ACC_RST    2048

`endif
